//--- source/be_config.svh
// sizes for the back end; BE_RP and both queue depths must be powers of two, BE_XLEN must be 32
`ifndef BE_CONFIG_SVH
`define BE_CONFIG_SVH

// architectural registers, register 0 included
`define BE_AREG_NUM 8

// physical copies kept per architectural register
`define BE_RP 4

`define BE_XLEN 32

// issue queue depths
`define BE_ALU_DP 4
`define BE_MUL_DP 4

// reorder FIFO depth
`define BE_ROB_DP 8

`endif

//--- source/be_pkg.sv
// shared back end types; widths follow be_config.svh and a physical register is {areg, copy}
`include "be_config.svh"

package be_pkg;

	typedef logic [`BE_XLEN-1:0] xlen_t;
	typedef logic [$clog2(`BE_AREG_NUM)-1:0] areg_t;
	typedef logic [$clog2(`BE_RP)-1:0] copy_t;

	// flat index into the physical file
	typedef struct packed {
		areg_t areg;
		copy_t copy;
	} preg_t;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_XOR,
		OP_MUL
	} op_e;

	// as decoded by the front end
	typedef struct packed {
		op_e   op;
		areg_t rd;
		areg_t rs1;
		areg_t rs2;
	} micro_instr_t;

	typedef struct packed {
		op_e   op;
		preg_t rd;
		preg_t rs1;
		preg_t rs2;
	} issue_info_t;

	typedef struct packed {
		op_e   op;
		preg_t rd;
		xlen_t op1;
		xlen_t op2;
	} exe_param_t;

	typedef struct packed {
		logic  valid;
		preg_t rd;
		xlen_t res;
	} wb_t;

	typedef struct packed {
		preg_t rd;
	} rob_info_t;

endpackage

//--- source/phy_register.sv
// rename state and data for all copies; reset makes copy 0 of each register live with value zero
`include "be_config.svh"

module phy_register (
	input  logic                                           CLK,
	input  logic                                           i_rst_n,
	input  logic                                           i_rename_valid,
	input  be_pkg::preg_t                                  i_rename_set,
	input  be_pkg::wb_t                                    i_alu_wb,
	input  be_pkg::wb_t                                    i_mul_wb,
	input  logic                                           i_commit_valid,
	input  be_pkg::preg_t                                  i_commit_preg,
	output be_pkg::xlen_t [`BE_AREG_NUM*`BE_RP-1:0]        o_regfile,
	output be_pkg::copy_t [`BE_AREG_NUM-1:0]               o_rn_act,
	output be_pkg::copy_t [`BE_AREG_NUM-1:0]               o_rn_arch,
	output logic          [`BE_AREG_NUM*`BE_RP-1:0]        o_rn_used,
	output logic          [`BE_AREG_NUM*`BE_RP-1:0]        o_wb_log
);

	be_pkg::preg_t old_preg;

	// copy being replaced in the architectural state
	assign old_preg = '{areg: i_commit_preg.areg, copy: o_rn_arch[i_commit_preg.areg]};

	always_ff @(posedge CLK) begin
		if (!i_rst_n) begin
			o_regfile <= '0;
			o_rn_act  <= '0;
			o_rn_arch <= '0;
			o_rn_used <= '0;
			o_wb_log  <= '0;
			for (int a = 0; a < `BE_AREG_NUM; a++) begin
				o_rn_used[a*`BE_RP] <= 1'b1;
				o_wb_log[a*`BE_RP]  <= 1'b1;
			end
		end else begin
			// new copy becomes the one later readers see
			if (i_rename_valid) begin
				o_rn_act[i_rename_set.areg] <= i_rename_set.copy;
				o_rn_used[i_rename_set]     <= 1'b1;
				o_wb_log[i_rename_set]      <= 1'b0;
			end
			if (i_alu_wb.valid) begin
				o_regfile[i_alu_wb.rd] <= i_alu_wb.res;
				o_wb_log[i_alu_wb.rd]  <= 1'b1;
			end
			if (i_mul_wb.valid) begin
				o_regfile[i_mul_wb.rd] <= i_mul_wb.res;
				o_wb_log[i_mul_wb.rd]  <= 1'b1;
			end
			// free the old copy
			if (i_commit_valid) begin
				o_rn_arch[i_commit_preg.areg] <= i_commit_preg.copy;
				o_rn_used[old_preg]           <= 1'b0;
				o_wb_log[old_preg]            <= 1'b0;
			end
		end
	end

	a_wb_distinct: assert property (@(posedge CLK) disable iff (!i_rst_n)
		i_alu_wb.valid && i_mul_wb.valid |-> i_alu_wb.rd != i_mul_wb.rd);

endmodule

//--- source/dispatch.sv
// one instruction per cycle; pop is combinational and stalls when no copy of rd is free
`include "be_config.svh"

module dispatch (
	input  be_pkg::micro_instr_t                      i_instr,
	input  logic                                      i_instr_empty,
	output logic                                      o_instr_pop,
	input  be_pkg::copy_t [`BE_AREG_NUM-1:0]          i_rn_act,
	input  logic          [`BE_AREG_NUM*`BE_RP-1:0]   i_rn_used,
	output logic                                      o_rename_valid,
	output be_pkg::preg_t                             o_rename_set,
	output logic                                      o_alu_push,
	output logic                                      o_mul_push,
	input  logic                                      i_alu_full,
	input  logic                                      i_mul_full,
	output be_pkg::issue_info_t                       o_issue_info,
	output logic                                      o_rob_push,
	output be_pkg::rob_info_t                         o_rob_info,
	input  logic                                      i_rob_full
);

	logic          is_mul;
	logic          queue_full;
	logic          copy_free;
	be_pkg::copy_t free_copy;

	assign is_mul     = i_instr.op == be_pkg::OP_MUL;
	assign queue_full = is_mul ? i_mul_full : i_alu_full;

	// lowest unused copy of rd
	always_comb begin
		copy_free = 1'b0;
		free_copy = '0;
		for (int i = `BE_RP - 1; i >= 0; i--) begin
			if (!i_rn_used[{i_instr.rd, be_pkg::copy_t'(i)}]) begin
				copy_free = 1'b1;
				free_copy = be_pkg::copy_t'(i);
			end
		end
	end

	assign o_instr_pop = !i_instr_empty && !queue_full && !i_rob_full && copy_free;

	assign o_rename_valid = o_instr_pop;
	assign o_rename_set   = '{areg: i_instr.rd, copy: free_copy};

	// sources see the active copy from before this rename
	assign o_issue_info.op  = i_instr.op;
	assign o_issue_info.rd  = o_rename_set;
	assign o_issue_info.rs1 = '{areg: i_instr.rs1, copy: i_rn_act[i_instr.rs1]};
	assign o_issue_info.rs2 = '{areg: i_instr.rs2, copy: i_rn_act[i_instr.rs2]};

	assign o_alu_push = o_instr_pop && !is_mul;
	assign o_mul_push = o_instr_pop && is_mul;

	assign o_rob_push    = o_instr_pop;
	assign o_rob_info.rd = o_rename_set;

endmodule

//--- source/issue_queue.sv
// in-order issue FIFO; DP must be a power of two and at least 2, only the head may launch
`include "be_config.svh"

module issue_queue #(
	parameter int DP = 4
) (
	input  logic                                      CLK,
	input  logic                                      i_rst_n,
	input  logic                                      i_push,
	input  be_pkg::issue_info_t                       i_info,
	output logic                                      o_full,
	input  logic          [`BE_AREG_NUM*`BE_RP-1:0]   i_wb_log,
	input  be_pkg::xlen_t [`BE_AREG_NUM*`BE_RP-1:0]   i_regfile,
	output logic                                      o_exe_valid,
	output be_pkg::exe_param_t                        o_exe
);

	localparam int AW = $clog2(DP);

	be_pkg::issue_info_t buffer [DP];
	be_pkg::issue_info_t head;
	logic [AW:0]         rd_ptr;
	logic [AW:0]         wr_ptr;
	logic                empty;
	logic                pop;

	// extra pointer bit tells full from empty
	assign empty  = rd_ptr == wr_ptr;
	assign o_full = (rd_ptr[AW] != wr_ptr[AW]) && (rd_ptr[AW-1:0] == wr_ptr[AW-1:0]);
	assign head   = buffer[rd_ptr[AW-1:0]];

	// launch once both sources are written back
	assign pop = !empty && i_wb_log[head.rs1] && i_wb_log[head.rs2];

	always_ff @(posedge CLK) begin
		if (!i_rst_n) begin
			rd_ptr      <= '0;
			wr_ptr      <= '0;
			o_exe_valid <= 1'b0;
		end else begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			o_exe_valid <= pop;
		end
	end

	always_ff @(posedge CLK) begin
		if (i_push)
			buffer[wr_ptr[AW-1:0]] <= i_info;
		if (pop)
			o_exe <= '{op: head.op, rd: head.rd,
				op1: i_regfile[head.rs1], op2: i_regfile[head.rs2]};
	end

	a_no_push_full: assert property (@(posedge CLK) disable iff (!i_rst_n) i_push |-> !o_full);

endmodule

//--- source/alu.sv
// one-cycle ALU; add and sub wrap at 32 bits, any code other than the four ALU ops yields zero

module alu (
	input  logic               CLK,
	input  logic               i_rst_n,
	input  logic               i_exe_valid,
	input  be_pkg::exe_param_t i_exe,
	output be_pkg::wb_t        o_wb
);

	be_pkg::xlen_t res;
	be_pkg::xlen_t wb_res;
	be_pkg::preg_t wb_rd;
	logic          wb_valid;

	always_comb begin
		case (i_exe.op)
			be_pkg::OP_ADD: res = i_exe.op1 + i_exe.op2;
			be_pkg::OP_SUB: res = i_exe.op1 - i_exe.op2;
			be_pkg::OP_AND: res = i_exe.op1 & i_exe.op2;
			be_pkg::OP_XOR: res = i_exe.op1 ^ i_exe.op2;
			default:        res = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!i_rst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= i_exe_valid;
	end

	always_ff @(posedge CLK) begin
		wb_res <= res;
		wb_rd  <= i_exe.rd;
	end

	assign o_wb = '{valid: wb_valid, rd: wb_rd, res: wb_res};

endmodule

//--- source/mul.sv
// three-stage multiplier, one issue per cycle, only the low 32 bits of the product come out
`include "be_config.svh"

module mul (
	input  logic               CLK,
	input  logic               i_rst_n,
	input  logic               i_exe_valid,
	input  be_pkg::exe_param_t i_exe,
	output be_pkg::wb_t        o_wb
);

	localparam int HW = `BE_XLEN / 2;

	logic [2:0]          valid_q;
	be_pkg::preg_t [2:0] rd_q;
	be_pkg::xlen_t       lo_lo;
	logic [HW-1:0]       lo_hi;
	logic [HW-1:0]       a_hi;
	logic [HW-1:0]       b_lo;
	be_pkg::xlen_t       sum;
	be_pkg::xlen_t       res;

	always_ff @(posedge CLK) begin
		if (!i_rst_n)
			valid_q <= '0;
		else
			valid_q <= {valid_q[1:0], i_exe_valid};
	end

	always_ff @(posedge CLK) begin
		rd_q <= {rd_q[1:0], i_exe.rd};
		// first partial products, upper cross term deferred
		lo_lo <= i_exe.op1[HW-1:0] * i_exe.op2[HW-1:0];
		lo_hi <= i_exe.op1[HW-1:0] * i_exe.op2[`BE_XLEN-1:HW];
		a_hi  <= i_exe.op1[`BE_XLEN-1:HW];
		b_lo  <= i_exe.op2[HW-1:0];
		// hi*hi falls outside the low word
		sum <= lo_lo + {lo_hi + HW'(a_hi * b_lo), {HW{1'b0}}};
		res <= sum;
	end

	assign o_wb = '{valid: valid_q[2], rd: rd_q[2], res: res};

endmodule

//--- source/commit.sv
// reorder FIFO with in-order retire, one per cycle; BE_ROB_DP must be a power of two
`include "be_config.svh"

module commit (
	input  logic                                      CLK,
	input  logic                                      i_rst_n,
	input  logic                                      i_rob_push,
	input  be_pkg::rob_info_t                         i_rob_info,
	output logic                                      o_rob_full,
	input  logic          [`BE_AREG_NUM*`BE_RP-1:0]   i_wb_log,
	input  be_pkg::xlen_t [`BE_AREG_NUM*`BE_RP-1:0]   i_regfile,
	input  be_pkg::copy_t [`BE_AREG_NUM-1:0]          i_rn_arch,
	output logic                                      o_commit_valid_int,
	output be_pkg::preg_t                             o_commit_preg,
	output logic                                      o_commit_valid,
	output be_pkg::areg_t                             o_commit_rd,
	output be_pkg::xlen_t                             o_commit_data
);

	localparam int AW = $clog2(`BE_ROB_DP);

	be_pkg::rob_info_t rob [`BE_ROB_DP];
	be_pkg::rob_info_t head;
	logic [AW:0]       rd_ptr;
	logic [AW:0]       wr_ptr;
	logic              empty;

	assign empty      = rd_ptr == wr_ptr;
	assign o_rob_full = (rd_ptr[AW] != wr_ptr[AW]) && (rd_ptr[AW-1:0] == wr_ptr[AW-1:0]);
	assign head       = rob[rd_ptr[AW-1:0]];

	// retire the oldest once its result is logged
	assign o_commit_valid_int = !empty && i_wb_log[head.rd];
	assign o_commit_preg      = head.rd;

	always_ff @(posedge CLK) begin
		if (!i_rst_n) begin
			rd_ptr         <= '0;
			wr_ptr         <= '0;
			o_commit_valid <= 1'b0;
		end else begin
			if (i_rob_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (o_commit_valid_int)
				rd_ptr <= rd_ptr + 1'b1;
			o_commit_valid <= o_commit_valid_int;
		end
	end

	always_ff @(posedge CLK) begin
		if (i_rob_push)
			rob[wr_ptr[AW-1:0]] <= i_rob_info;
		o_commit_rd   <= head.rd.areg;
		o_commit_data <= i_regfile[head.rd];
	end

	a_no_push_full: assert property (@(posedge CLK) disable iff (!i_rst_n)
		i_rob_push |-> !o_rob_full);

	// a retiring copy was renamed from a free one, never the live architectural copy
	a_new_copy: assert property (@(posedge CLK) disable iff (!i_rst_n)
		o_commit_valid_int |-> i_rn_arch[head.rd.areg] != head.rd.copy);

endmodule

//--- source/back_end.sv
// integer back end without branch, memory or trap handling; i_instr must hold while not popped
`include "be_config.svh"

module back_end (
	input  logic                 CLK,
	input  logic                 i_rst_n,
	input  be_pkg::micro_instr_t i_instr,
	input  logic                 i_instr_empty,
	output logic                 o_instr_pop,
	output logic                 o_commit_valid,
	output be_pkg::areg_t        o_commit_rd,
	output be_pkg::xlen_t        o_commit_data
);

	be_pkg::xlen_t [`BE_AREG_NUM*`BE_RP-1:0] regfile;
	be_pkg::copy_t [`BE_AREG_NUM-1:0]        rn_act;
	be_pkg::copy_t [`BE_AREG_NUM-1:0]        rn_arch;
	logic [`BE_AREG_NUM*`BE_RP-1:0]          rn_used;
	logic [`BE_AREG_NUM*`BE_RP-1:0]          wb_log;

	logic                rename_valid;
	be_pkg::preg_t       rename_set;
	logic                alu_push, mul_push, alu_full, mul_full;
	be_pkg::issue_info_t issue_info;
	logic                rob_push, rob_full;
	be_pkg::rob_info_t   rob_info;
	logic                alu_exe_valid, mul_exe_valid;
	be_pkg::exe_param_t  alu_exe, mul_exe;
	be_pkg::wb_t         alu_wb, mul_wb;
	logic                commit_valid_int;
	be_pkg::preg_t       commit_preg;

	dispatch i_dispatch (.i_instr, .i_instr_empty, .o_instr_pop, .i_rn_act(rn_act),
		.i_rn_used(rn_used), .o_rename_valid(rename_valid), .o_rename_set(rename_set),
		.o_alu_push(alu_push), .o_mul_push(mul_push), .i_alu_full(alu_full),
		.i_mul_full(mul_full), .o_issue_info(issue_info), .o_rob_push(rob_push),
		.o_rob_info(rob_info), .i_rob_full(rob_full));

	issue_queue #(.DP(`BE_ALU_DP)) i_alu_issue_queue (.CLK, .i_rst_n, .i_push(alu_push),
		.i_info(issue_info), .o_full(alu_full), .i_wb_log(wb_log), .i_regfile(regfile),
		.o_exe_valid(alu_exe_valid), .o_exe(alu_exe));

	issue_queue #(.DP(`BE_MUL_DP)) i_mul_issue_queue (.CLK, .i_rst_n, .i_push(mul_push),
		.i_info(issue_info), .o_full(mul_full), .i_wb_log(wb_log), .i_regfile(regfile),
		.o_exe_valid(mul_exe_valid), .o_exe(mul_exe));

	alu i_alu (.CLK, .i_rst_n, .i_exe_valid(alu_exe_valid), .i_exe(alu_exe), .o_wb(alu_wb));

	mul i_mul (.CLK, .i_rst_n, .i_exe_valid(mul_exe_valid), .i_exe(mul_exe), .o_wb(mul_wb));

	commit i_commit (.CLK, .i_rst_n, .i_rob_push(rob_push), .i_rob_info(rob_info),
		.o_rob_full(rob_full), .i_wb_log(wb_log), .i_regfile(regfile), .i_rn_arch(rn_arch),
		.o_commit_valid_int(commit_valid_int), .o_commit_preg(commit_preg),
		.o_commit_valid, .o_commit_rd, .o_commit_data);

	phy_register i_phy_register (.CLK, .i_rst_n, .i_rename_valid(rename_valid),
		.i_rename_set(rename_set), .i_alu_wb(alu_wb), .i_mul_wb(mul_wb),
		.i_commit_valid(commit_valid_int), .i_commit_preg(commit_preg), .o_regfile(regfile),
		.o_rn_act(rn_act), .o_rn_arch(rn_arch), .o_rn_used(rn_used), .o_wb_log(wb_log));

endmodule

//--- testbench/tb_back_end.sv
// random stimulus from a fixed seed; registers start at zero, five tests of 80 instructions
`include "be_config.svh"

module tb_back_end;

	localparam int TEST_LEN       = 80;
	localparam int NUM_TESTS      = 5;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_LEN * 40;

	logic                 CLK;
	logic                 i_rst_n;
	be_pkg::micro_instr_t i_instr;
	logic                 i_instr_empty;
	logic                 o_instr_pop;
	logic                 o_commit_valid;
	be_pkg::areg_t        o_commit_rd;
	be_pkg::xlen_t        o_commit_data;

	// architectural model and expected commits in pop order
	be_pkg::xlen_t arch [`BE_AREG_NUM];
	be_pkg::areg_t exp_rd_q [$];
	be_pkg::xlen_t exp_data_q [$];
	be_pkg::xlen_t pop_res;
	int            errors;
	int            pop_count;
	int            commit_count;
	int            cycle_count;
	logic          taken;

	back_end i_back_end (.CLK, .i_rst_n, .i_instr, .i_instr_empty, .o_instr_pop,
		.o_commit_valid, .o_commit_rd, .o_commit_data);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s = %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic be_pkg::xlen_t model_op(be_pkg::op_e op, be_pkg::xlen_t a,
		be_pkg::xlen_t b);
		case (op)
			be_pkg::OP_ADD: return a + b;
			be_pkg::OP_SUB: return a - b;
			be_pkg::OP_AND: return a & b;
			be_pkg::OP_XOR: return a ^ b;
			be_pkg::OP_MUL: return a * b;
			default:        return '0;
		endcase
	endfunction

	// mode 0 alu only, 1 mul heavy, 2 two-register chains, 3 one rd, 4 anything
	function automatic be_pkg::micro_instr_t gen_instr(int mode, be_pkg::areg_t burst_rd);
		be_pkg::micro_instr_t ins;
		ins.op  = be_pkg::op_e'(mode == 0 ? $urandom % 4 : $urandom % 5);
		ins.rd  = be_pkg::areg_t'($urandom);
		ins.rs1 = be_pkg::areg_t'($urandom);
		ins.rs2 = be_pkg::areg_t'($urandom);
		if (mode == 1 && $urandom % 2)
			ins.op = be_pkg::OP_MUL;
		if (mode == 2) begin
			ins.rd  = be_pkg::areg_t'($urandom % 2);
			ins.rs1 = be_pkg::areg_t'($urandom % 2);
			ins.rs2 = be_pkg::areg_t'($urandom % 2);
		end
		if (mode == 3)
			ins.rd = burst_rd;
		return ins;
	endfunction

	function automatic logic pick_empty(int mode);
		if (mode == 3)
			return $urandom % 2;
		if (mode == 4)
			return $urandom % 4 == 0;
		return $urandom % 8 == 0;
	endfunction

	// pop is combinational, so read it before the edge updates the DUT state
	always @(posedge CLK) begin
		if (i_rst_n && o_instr_pop) begin
			pop_res = model_op(i_instr.op, arch[i_instr.rs1], arch[i_instr.rs2]);
			arch[i_instr.rd] = pop_res;
			exp_rd_q.push_back(i_instr.rd);
			exp_data_q.push_back(pop_res);
			pop_count++;
			taken = 1'b1;
		end
	end

	always @(negedge CLK) begin
		if (i_rst_n && o_commit_valid) begin
			if (exp_rd_q.size() == 0) begin
				$display("commit at time %0t with no instruction outstanding", $time);
				errors++;
			end else begin
				check("o_commit_rd", o_commit_rd, exp_rd_q.pop_front());
				check("o_commit_data", o_commit_data, exp_data_q.pop_front());
			end
			commit_count++;
		end
	end

	task automatic run_test(input string name, input int mode);
		int            start_errors;
		int            start_pops;
		be_pkg::areg_t burst_rd;
		start_errors = errors;
		start_pops   = pop_count;
		burst_rd     = be_pkg::areg_t'($urandom);
		taken        = 1'b0;
		i_instr      = gen_instr(mode, burst_rd);
		while (pop_count - start_pops < TEST_LEN) begin
			i_instr_empty = pick_empty(mode);
			@(negedge CLK);
			if (taken) begin
				taken   = 1'b0;
				i_instr = gen_instr(mode, burst_rd);
			end
		end
		i_instr_empty = 1'b1;
		wait (commit_count == pop_count);
		// commits are counted on falling edges, so look between them
		repeat (2) @(posedge CLK);
		check("outstanding", exp_rd_q.size(), 0);
		check("commit_count", commit_count, pop_count);
		@(negedge CLK);
		$display("test %s: %0d instructions, %0d errors", name, TEST_LEN,
			errors - start_errors);
	endtask

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge CLK);
			cycle_count++;
		end
		$display("run hung: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h32fb609d));
		errors        = 0;
		pop_count     = 0;
		commit_count  = 0;
		taken         = 1'b0;
		i_rst_n       = 1'b0;
		i_instr       = '0;
		i_instr_empty = 1'b1;
		for (int r = 0; r < `BE_AREG_NUM; r++)
			arch[r] = '0;
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		i_rst_n = 1'b1;

		// nothing may move while the front end is empty
		repeat (10) begin
			@(negedge CLK);
			check("o_instr_pop", o_instr_pop, 0);
			check("o_commit_valid", o_commit_valid, 0);
		end
		$display("test idle_after_reset: 10 cycles, %0d errors", errors);

		run_test("alu_only", 0);
		run_test("mul_mixed", 1);
		run_test("dependent_chain", 2);
		run_test("rd_burst", 3);
		run_test("random_mix", 4);

		$display("%0d pops, %0d commits, %0d errors", pop_count, commit_count, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- tb.f
+incdir+source
source/be_pkg.sv
source/phy_register.sv
source/dispatch.sv
source/issue_queue.sv
source/alu.sv
source/mul.sv
source/commit.sv
source/back_end.sv
testbench/tb_back_end.sv
